// ==== run_sim.sh ====
#!/bin/sh
# Build and run the photo-frame core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_pframe -o sim_tb
status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
	echo "Run FAILED, see sim.log"
	exit 1
fi
echo "Run passed"

// ==== sim.f ====
verilog/soc_pkg.sv
verilog/reset_seq.sv
verilog/sys_bus_switch.sv
verilog/boot_rom.sv
verilog/csr_bridge.sv
verilog/sysctl_regs.sv
verilog/pframe_core.sv
testbench/pframe_props.sv
testbench/tb_pframe.sv

// ==== testbench/pframe_golden.txt ====
# op addr wdata expected, all hex
# op 0 read, 1 write, 2 wait irq (expected is cycle limit), 3 wait reset (expected is hold length)
0 00000000 00000000 98000000
0 00000010 00000000 34020001
0 80000004 00000000 d0000000
0 0000002c 00000000 38210400
0 8000003c 00000000 34000000
1 30001000 000000a5 00000000
0 30001000 00000000 00000005
0 30001010 00000000 20181125
0 b0001010 00000000 20181125
0 10000000 00000000 00000000
0 40000000 00000000 00000000
0 c0000000 00000000 00000000
0 30002000 00000000 00000000
1 30001008 00000014 00000000
1 30001004 00000001 00000000
2 00000000 00000000 0000001e
0 30001004 00000000 00000003
1 30001004 00000000 00000000
0 30001004 00000000 00000000
1 30001000 0000000c 00000000
1 30001008 00000055 00000000
1 30001014 00000001 00000000
3 00000000 00000000 00000010
0 30001000 00000000 00000000
0 30001008 00000000 00000000
0 30001010 00000000 20181125

// ==== testbench/pframe_props.sv ====
`timescale 1ns/1ps

module pframe_props import soc_pkg::*; (
	input	logic		sys_clk,
	input	logic		hard_reset,
	input	wb_req_t	wb_req_i,
	input	wb_rsp_t	wb_rsp_o,
	input	logic		sys_rst_o
);

	// Single-cycle ack pulse
	ack_pulse: assert property (@(posedge sys_clk) disable iff (hard_reset)
		wb_rsp_o.ack |=> !wb_rsp_o.ack)
		else $error("ack stayed high for more than one cycle");

	ack_needs_cyc: assert property (@(posedge sys_clk) disable iff (hard_reset)
		wb_rsp_o.ack |-> wb_req_i.cyc)
		else $error("ack seen without an open bus cycle");

	// Master holds the whole request until it sees ack
	req_stable: assert property (@(posedge sys_clk) disable iff (hard_reset)
		(wb_req_i.cyc && !wb_rsp_o.ack) |=> $stable(wb_req_i))
		else $error("bus request changed before ack");

	no_ack_in_reset: assert property (@(posedge sys_clk) disable iff (hard_reset)
		sys_rst_o |-> !wb_rsp_o.ack)
		else $error("ack seen during system reset");

endmodule

// ==== testbench/tb_pframe.sv ====
`timescale 1ns/1ps

module tb_pframe import soc_pkg::*; ();

	localparam int CLK_HALF = 20;		// 40 ns period
	localparam int ACK_LIMIT = 16;		// Cycles before an ack counts as missing
	localparam int RISE_LIMIT = 8;
	localparam logic [3:0] OP_READ = 4'h0;
	localparam logic [3:0] OP_WRITE = 4'h1;
	localparam logic [3:0] OP_WAIT_IRQ = 4'h2;
	localparam logic [3:0] OP_WAIT_RST = 4'h3;

	logic sys_clk = 1'b0;
	logic hard_reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [GPIO_W-1:0] gpio;
	logic timer_irq;
	logic sys_rst;

	// One golden transaction per entry
	logic [3:0] op_q [$];
	logic [ADDR_W-1:0] adr_q [$];
	logic [DATA_W-1:0] wd_q [$];
	logic [DATA_W-1:0] exp_q [$];
	int cycle_cnt = 0;
	int cycle_limit = 0;	// Zero until the golden file is loaded
	logic [GPIO_W-1:0] exp_gpio;

	always #CLK_HALF sys_clk = ~sys_clk;

	pframe_core i_dut (
		.sys_clk		(sys_clk),
		.hard_reset		(hard_reset),
		.wb_req_i		(wb_req),
		.wb_rsp_o		(wb_rsp),
		.gpio_o			(gpio),
		.timer_irq_o	(timer_irq),
		.sys_rst_o		(sys_rst)
	);

	bind pframe_core pframe_props i_props (
		.sys_clk	(sys_clk),
		.hard_reset	(hard_reset),
		.wb_req_i	(wb_req_i),
		.wb_rsp_o	(wb_rsp_o),
		.sys_rst_o	(sys_rst_o)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	// Watchdog over the whole run
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			abort_run($sformatf("Timeout, run exceeded %0d cycles", cycle_limit));
		end
	end

	task automatic check_rsp_data(input logic [ADDR_W-1:0] adr, input wb_rsp_t got,
			input logic [DATA_W-1:0] exp);
		if (got.dat !== exp) begin
			abort_run($sformatf("Mismatch at %0t: wb_rsp_o.dat (addr %h) got %h expected %h",
				$time, adr, got.dat, exp));
		end
	endtask

	task automatic check_gpio(input logic [GPIO_W-1:0] got, input logic [GPIO_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch at %0t: gpio_o got %h expected %h", $time, got, exp));
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch at %0t: timer_irq_o got %b expected %b",
				$time, got, exp));
		end
	endtask

	task automatic check_reset_len(input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("Mismatch at %0t: sys_rst_o length got %0d expected %0d",
				$time, got, exp));
		end
	endtask

	task automatic check_ack_latency(input logic [ADDR_W-1:0] adr, input int got,
			input int exp);
		if (got != exp) begin
			abort_run($sformatf("Mismatch at %0t: ack latency (addr %h) got %0d expected %0d",
				$time, adr, got, exp));
		end
	endtask

	// ROM and unmapped targets answer in one cycle
	function automatic int expected_latency(input logic [ADDR_W-1:0] adr, input logic we);
		if (adr[REGION_LSB +: REGION_W] != REGION_CSR) begin
			return 1;
		end
		return we ? 2 : 3;	// Reads pass through the wait state
	endfunction

	function automatic logic is_sysctl_reg(input logic [ADDR_W-1:0] adr,
			input logic [CSR_BANK_LSB-1:0] ofs);
		logic [CSR_A_W-1:0] wa;
		wa = adr[2 +: CSR_A_W];	// CSR word address
		return (adr[REGION_LSB +: REGION_W] == REGION_CSR)
			&& (wa[CSR_BANK_LSB +: CSR_BANK_W] == CSR_BANK_SYSCTL)
			&& (wa[CSR_BANK_LSB-1:0] == ofs);
	endfunction

	task automatic load_golden();
		int fd;
		int n;
		string line;
		logic [3:0] op;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		logic [DATA_W-1:0] e;
		fd = $fopen("testbench/pframe_golden.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open testbench/pframe_golden.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%h %h %h %h", op, a, d, e);	// Comment lines give 0
			if (n == 4) begin
				op_q.push_back(op);
				adr_q.push_back(a);
				wd_q.push_back(d);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	// One Wishbone cycle returning the ack cycle response and its latency
	task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] dat, output wb_rsp_t rsp, output int lat);
		wb_req_t req;
		req = '0;
		req.adr = adr;
		req.dat = dat;
		req.sel = '1;
		req.we = we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		@(posedge sys_clk);
		wb_req <= req;
		@(posedge sys_clk);		// DUT samples the request here
		lat = 0;
		do begin
			@(posedge sys_clk);
			lat = lat + 1;
			if (lat > ACK_LIMIT) begin
				abort_run($sformatf("No ack for the access to address %h", adr));
			end
		end while (wb_rsp.ack !== 1'b1);
		rsp = wb_rsp;
		wb_req <= '0;	// Drop cyc and stb for the next cycle
	endtask

	task automatic wait_irq(input int limit);
		int n;
		n = 0;
		while (timer_irq !== 1'b1) begin
			@(posedge sys_clk);
			n = n + 1;
			if (n > limit) begin
				abort_run($sformatf("timer_irq_o did not rise within %0d cycles", limit));
			end
		end
	endtask

	// Counts sampled cycles of sys_rst_o high
	task automatic measure_reset(output int len);
		int n;
		n = 0;
		while (sys_rst !== 1'b1) begin
			@(posedge sys_clk);
			n = n + 1;
			if (n > RISE_LIMIT) begin
				abort_run("sys_rst_o did not rise after the reset request");
			end
		end
		len = 0;
		while (sys_rst === 1'b1) begin
			len = len + 1;
			@(posedge sys_clk);
			if (len > 4 * RESET_HOLD) begin
				abort_run("sys_rst_o stuck high");
			end
		end
	endtask

	initial begin
		wb_rsp_t rsp;
		int lat;
		int len;
		int done;
		hard_reset <= 1'b1;
		wb_req <= '0;
		exp_gpio = '0;
		done = 0;
		load_golden();
		cycle_limit = op_q.size() * 8 + 4 * RESET_HOLD + 200;

		repeat (2) @(posedge sys_clk);
		hard_reset <= 1'b0;
		@(posedge sys_clk);		// First cycle out of hard reset
		measure_reset(len);
		check_reset_len(len, RESET_HOLD);
		check_gpio(gpio, '0);
		check_irq(timer_irq, 1'b0);

		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				OP_READ: begin
					bus_access(1'b0, adr_q[i], '0, rsp, lat);
					check_ack_latency(adr_q[i], lat, expected_latency(adr_q[i], 1'b0));
					check_rsp_data(adr_q[i], rsp, exp_q[i]);
				end
				OP_WRITE: begin
					bus_access(1'b1, adr_q[i], wd_q[i], rsp, lat);
					check_ack_latency(adr_q[i], lat, expected_latency(adr_q[i], 1'b1));
					if (is_sysctl_reg(adr_q[i], REG_GPIO_OUT)) begin
						exp_gpio = wd_q[i][GPIO_W-1:0];
					end
					if (is_sysctl_reg(adr_q[i], REG_TIMER_CTRL)) begin
						check_irq(timer_irq, 1'b0);	// Control write clears irq
					end
				end
				OP_WAIT_IRQ: wait_irq(int'(exp_q[i]));
				OP_WAIT_RST: begin
					measure_reset(len);
					check_reset_len(len, int'(exp_q[i]));
					exp_gpio = '0;
					check_irq(timer_irq, 1'b0);
				end
				default: begin
					abort_run($sformatf("Unknown operation %h in golden line %0d",
						op_q[i], i));
				end
			endcase
			check_gpio(gpio, exp_gpio);
			done = done + 1;
		end

		if (done == 0) begin
			abort_run("Golden file held no transactions");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== verilog/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
	input	logic		sys_clk,
	input	logic		hard_reset,
	input	logic		sys_rst_i,
	input	wb_req_t	req_i,
	output	wb_rsp_t	rsp_o
);

	logic [BOOT_IDX_W-1:0] word_idx;
	logic req_new;
	logic ack_q;
	logic [DATA_W-1:0] dat_q;

	assign word_idx = req_i.adr[2 +: BOOT_IDX_W];	// Wraps over the image
	assign req_new = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			ack_q <= 1'b0;
			dat_q <= '0;
		end else if (sys_rst_i) begin
			ack_q <= 1'b0;
			dat_q <= '0;
		end else begin
			ack_q <= req_new;	// One cycle after sampling
			// Writes are acked but return nothing
			if (req_new) begin
				dat_q <= req_i.we ? '0 : BOOT_IMAGE[word_idx];
			end
		end
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;

endmodule

// ==== verilog/csr_bridge.sv ====
`timescale 1ns/1ps

module csr_bridge import soc_pkg::*; (
	input	logic				sys_clk,
	input	logic				hard_reset,
	input	logic				sys_rst_i,
	input	wb_req_t			wb_req_i,
	output	wb_rsp_t			wb_rsp_o,
	output	csr_req_t			csr_o,
	input	logic [DATA_W-1:0]	csr_rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STROBE,	// CSR access on the bus
		ST_WAIT,	// Slave registers read data
		ST_ACK
	} state_t;

	state_t state;
	logic req;
	logic we_q;
	logic [CSR_A_W-1:0] adr_q;
	logic [DATA_W-1:0] dw_q;
	logic [DATA_W-1:0] rdata_q;

	assign req = wb_req_i.cyc & wb_req_i.stb;

	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			state <= ST_IDLE;
			we_q <= 1'b0;
		end else if (sys_rst_i) begin
			state <= ST_IDLE;
			we_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req) begin
						state <= ST_STROBE;
						we_q <= wb_req_i.we;
					end
				end
				ST_STROBE: state <= we_q ? ST_ACK : ST_WAIT;	// Writes need no data
				ST_WAIT: state <= ST_ACK;
				ST_ACK: state <= ST_IDLE;	// Master drops cyc next cycle
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Transaction payload
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			adr_q <= '0;
			dw_q <= '0;
			rdata_q <= '0;
		end else if (sys_rst_i) begin
			adr_q <= '0;
			dw_q <= '0;
			rdata_q <= '0;
		end else if (state == ST_IDLE && req) begin
			adr_q <= wb_req_i.adr[2 +: CSR_A_W];	// Byte to word address
			dw_q <= wb_req_i.dat;
			rdata_q <= '0;
		end else if (state == ST_WAIT) begin
			rdata_q <= csr_rdata_i;
		end
	end

	assign csr_o = '{a: adr_q, we: we_q, dw: dw_q, valid: (state == ST_STROBE)};
	assign wb_rsp_o = '{dat: rdata_q, ack: (state == ST_ACK)};

endmodule

// ==== verilog/pframe_core.sv ====
`timescale 1ns/1ps

module pframe_core import soc_pkg::*; (
	input	logic				sys_clk,
	input	logic				hard_reset,
	input	wb_req_t			wb_req_i,
	output	wb_rsp_t			wb_rsp_o,
	output	logic [GPIO_W-1:0]	gpio_o,
	output	logic				timer_irq_o,
	output	logic				sys_rst_o		// Also feeds every block
);

	wb_req_t rom_req;
	wb_rsp_t rom_rsp;
	wb_req_t csr_wb_req;
	wb_rsp_t csr_wb_rsp;
	csr_req_t csr_req;
	logic [DATA_W-1:0] csr_rdata;
	logic soft_reset;

	reset_seq i_reset_seq (
		.sys_clk		(sys_clk),
		.hard_reset		(hard_reset),
		.soft_reset_i	(soft_reset),
		.sys_rst_o		(sys_rst_o)
	);

	// Region decode, bit 31 ignored
	sys_bus_switch i_switch (
		.sys_clk	(sys_clk),
		.hard_reset	(hard_reset),
		.sys_rst_i	(sys_rst_o),
		.m_req_i	(wb_req_i),
		.m_rsp_o	(wb_rsp_o),
		.rom_req_o	(rom_req),
		.rom_rsp_i	(rom_rsp),
		.csr_req_o	(csr_wb_req),
		.csr_rsp_i	(csr_wb_rsp)
	);

	boot_rom i_rom (
		.sys_clk	(sys_clk),
		.hard_reset	(hard_reset),
		.sys_rst_i	(sys_rst_o),
		.req_i		(rom_req),
		.rsp_o		(rom_rsp)
	);

	csr_bridge i_csrbrg (
		.sys_clk		(sys_clk),
		.hard_reset		(hard_reset),
		.sys_rst_i		(sys_rst_o),
		.wb_req_i		(csr_wb_req),
		.wb_rsp_o		(csr_wb_rsp),
		.csr_o			(csr_req),
		.csr_rdata_i	(csr_rdata)		// Only bank on the CSR bus
	);

	sysctl_regs i_sysctl (
		.sys_clk		(sys_clk),
		.hard_reset		(hard_reset),
		.sys_rst_i		(sys_rst_o),
		.csr_i			(csr_req),
		.csr_rdata_o	(csr_rdata),
		.gpio_o			(gpio_o),
		.timer_irq_o	(timer_irq_o),
		.soft_reset_o	(soft_reset)
	);

endmodule

// ==== verilog/reset_seq.sv ====
`timescale 1ns/1ps

module reset_seq import soc_pkg::*; (
	input	logic	sys_clk,
	input	logic	hard_reset,
	input	logic	soft_reset_i,	// One-cycle pulse from sysctl
	output	logic	sys_rst_o
);

	// Sized to hold RESET_HOLD itself
	logic [$clog2(RESET_HOLD+1)-1:0] hold_cnt;

	// Either source reloads the count, release only once it drains
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			hold_cnt <= RESET_HOLD[$bits(hold_cnt)-1:0];
		end else if (soft_reset_i) begin
			hold_cnt <= RESET_HOLD[$bits(hold_cnt)-1:0];	// Restart stretch
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign sys_rst_o = (hold_cnt != '0);	// Held through the whole count

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;
	localparam int CSR_A_W = 14;		// CSR word address
	localparam int GPIO_W = 4;

	// Cycles of system reset after the last source goes away
	localparam int RESET_HOLD = 16;

	// Region field sits in bits 30..28, bit 31 is the shadow bit
	localparam int REGION_LSB = 28;
	localparam int REGION_W = 3;
	localparam logic [REGION_W-1:0] REGION_ROM = 3'd0;
	localparam logic [REGION_W-1:0] REGION_CSR = 3'd3;

	// CSR bank select and register offsets
	localparam int CSR_BANK_LSB = 10;
	localparam int CSR_BANK_W = 4;
	localparam logic [CSR_BANK_W-1:0] CSR_BANK_SYSCTL = 4'd1;
	localparam logic [CSR_BANK_LSB-1:0] REG_GPIO_OUT = 10'd0;
	localparam logic [CSR_BANK_LSB-1:0] REG_TIMER_CTRL = 10'd1;	// Bit 0 enable, bit 1 irq
	localparam logic [CSR_BANK_LSB-1:0] REG_TIMER_CMP = 10'd2;
	localparam logic [CSR_BANK_LSB-1:0] REG_TIMER_CNT = 10'd3;
	localparam logic [CSR_BANK_LSB-1:0] REG_SYSTEM_ID = 10'd4;
	localparam logic [CSR_BANK_LSB-1:0] REG_SOFT_RESET = 10'd5;
	localparam logic [DATA_W-1:0] SYSTEM_ID = 32'h2018_1125;

	// Boot image
	localparam int BOOT_WORDS = 8;
	localparam int BOOT_IDX_W = 3;
	localparam logic [DATA_W-1:0] BOOT_IMAGE [BOOT_WORDS] = '{
		32'h9800_0000,		// xor r0, r0, r0
		32'hD000_0000,		// Interrupts off
		32'h7801_3000,		// CSR base high half
		32'h3821_0400,		// Sysctl bank
		32'h3402_0001,
		32'h5822_0000,		// GPIO out
		32'hE000_0000,		// Spin
		32'h3400_0000
	};

	typedef struct packed {
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
		logic [SEL_W-1:0] sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] dat;
		logic ack;
	} wb_rsp_t;

	typedef struct packed {
		logic [CSR_A_W-1:0] a;
		logic we;
		logic [DATA_W-1:0] dw;
		logic valid;
	} csr_req_t;

endpackage

// ==== verilog/sys_bus_switch.sv ====
`timescale 1ns/1ps

module sys_bus_switch import soc_pkg::*; (
	input	logic		sys_clk,
	input	logic		hard_reset,
	input	logic		sys_rst_i,
	input	wb_req_t	m_req_i,
	output	wb_rsp_t	m_rsp_o,
	output	wb_req_t	rom_req_o,
	input	wb_rsp_t	rom_rsp_i,
	output	wb_req_t	csr_req_o,
	input	wb_rsp_t	csr_rsp_i
);

	logic [REGION_W-1:0] region;
	logic sel_rom;
	logic sel_csr;
	logic sel_none;		// Flash, SDRAM and the rest
	logic unm_ack;

	// Bit 31 left out so shadow addresses alias the base
	assign region = m_req_i.adr[REGION_LSB +: REGION_W];
	assign sel_rom = (region == REGION_ROM);
	assign sel_csr = (region == REGION_CSR);
	assign sel_none = ~sel_rom & ~sel_csr;

	// Same request to both targets, only the selected one sees a cycle
	always_comb begin
		rom_req_o = m_req_i;
		rom_req_o.cyc = m_req_i.cyc & sel_rom;
		rom_req_o.stb = m_req_i.stb & sel_rom;
		csr_req_o = m_req_i;
		csr_req_o.cyc = m_req_i.cyc & sel_csr;
		csr_req_o.stb = m_req_i.stb & sel_csr;
	end

	// Default target so an unmapped access never hangs the master
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			unm_ack <= 1'b0;
		end else if (sys_rst_i) begin
			unm_ack <= 1'b0;
		end else begin
			// Single-cycle pulse, master still holds stb in the ack cycle
			unm_ack <= m_req_i.cyc & m_req_i.stb & sel_none & ~unm_ack;
		end
	end

	// Request stays stable until ack, so the decode can steer the return path
	always_comb begin
		if (sel_rom) begin
			m_rsp_o = rom_rsp_i;
		end else if (sel_csr) begin
			m_rsp_o = csr_rsp_i;
		end else begin
			m_rsp_o.dat = '0;	// Unmapped reads as zero
			m_rsp_o.ack = unm_ack;
		end
	end

endmodule

// ==== verilog/sysctl_regs.sv ====
`timescale 1ns/1ps

module sysctl_regs import soc_pkg::*; (
	input	logic				sys_clk,
	input	logic				hard_reset,
	input	logic				sys_rst_i,
	input	csr_req_t			csr_i,
	output	logic [DATA_W-1:0]	csr_rdata_o,
	output	logic [GPIO_W-1:0]	gpio_o,
	output	logic				timer_irq_o,
	output	logic				soft_reset_o
);

	logic bank_hit;
	logic [CSR_BANK_LSB-1:0] reg_ofs;
	logic wr_en;
	logic rd_en;
	logic [DATA_W-1:0] rd_mux;

	logic [GPIO_W-1:0] gpio_q;
	logic tmr_en;
	logic tmr_irq;		// Sticky until control write
	logic [DATA_W-1:0] tmr_cmp;
	logic [DATA_W-1:0] tmr_cnt;
	logic soft_rst_q;
	logic [DATA_W-1:0] rdata_q;

	assign bank_hit = (csr_i.a[CSR_BANK_LSB +: CSR_BANK_W] == CSR_BANK_SYSCTL);
	assign reg_ofs = csr_i.a[CSR_BANK_LSB-1:0];
	assign wr_en = csr_i.valid & csr_i.we & bank_hit;
	assign rd_en = csr_i.valid & ~csr_i.we & bank_hit;

	// Read decode
	always_comb begin
		rd_mux = '0;
		case (reg_ofs)
			REG_GPIO_OUT: rd_mux[GPIO_W-1:0] = gpio_q;	// Upper bits read zero
			REG_TIMER_CTRL: rd_mux[1:0] = {tmr_irq, tmr_en};
			REG_TIMER_CMP: rd_mux = tmr_cmp;
			REG_TIMER_CNT: rd_mux = tmr_cnt;
			REG_SYSTEM_ID: rd_mux = SYSTEM_ID;
			default: rd_mux = '0;	// Soft reset and holes
		endcase
	end

	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			gpio_q <= '0;
			tmr_en <= 1'b0;
			tmr_irq <= 1'b0;
			tmr_cmp <= '0;
			tmr_cnt <= '0;
			soft_rst_q <= 1'b0;
			rdata_q <= '0;
		end else if (sys_rst_i) begin
			gpio_q <= '0;
			tmr_en <= 1'b0;
			tmr_irq <= 1'b0;
			tmr_cmp <= '0;
			tmr_cnt <= '0;
			soft_rst_q <= 1'b0;
			rdata_q <= '0;
		end else begin
			// Free-running compare timer
			if (tmr_en) begin
				if (tmr_cnt == tmr_cmp) begin
					tmr_cnt <= '0;
					tmr_irq <= 1'b1;
				end else begin
					tmr_cnt <= tmr_cnt + 1'b1;
				end
			end

			// Register writes win over the timer update
			soft_rst_q <= wr_en && (reg_ofs == REG_SOFT_RESET);	// Any value pulses
			if (wr_en) begin
				case (reg_ofs)
					REG_GPIO_OUT: gpio_q <= csr_i.dw[GPIO_W-1:0];
					REG_TIMER_CTRL: begin
						tmr_en <= csr_i.dw[0];
						tmr_irq <= 1'b0;	// Ack of the interrupt
					end
					REG_TIMER_CMP: tmr_cmp <= csr_i.dw;
					REG_TIMER_CNT: tmr_cnt <= csr_i.dw;
					default: ;
				endcase
			end

			rdata_q <= rd_en ? rd_mux : '0;	// Zero outside this bank
		end
	end

	assign csr_rdata_o = rdata_q;
	assign gpio_o = gpio_q;
	assign timer_irq_o = tmr_irq;
	assign soft_reset_o = soft_rst_q;

endmodule
